/* vdp_reg_pkg.sv */
// Register numbers, field widths and control types of the VDP register unit
// Only the registers kept by this unit have numbers here
// Mode enum covers the standard MSX2 screen modes, anything else is undefined

package vdp_reg_pkg;

  localparam int REG_NUM_W    = 6;
  localparam int REG_DATA_W   = 8;
  localparam int STATUS_SEL_W = 4;
  localparam int PAL_IDX_W    = 4;
  localparam int PAL_DEPTH    = 1 << PAL_IDX_W;

  typedef logic [REG_NUM_W-1:0]    reg_num_t;
  typedef logic [REG_DATA_W-1:0]   reg_data_t;
  typedef logic [STATUS_SEL_W-1:0] status_sel_t;
  typedef logic [PAL_IDX_W-1:0]    pal_idx_t;

  // ------------------------------------------------------------
  // Register numbers
  // ------------------------------------------------------------
  localparam reg_num_t REG_R0  = 6'd0;
  localparam reg_num_t REG_R1  = 6'd1;
  localparam reg_num_t REG_R7  = 6'd7;
  localparam reg_num_t REG_R9  = 6'd9;
  localparam reg_num_t REG_R15 = 6'd15;
  localparam reg_num_t REG_R16 = 6'd16;
  localparam reg_num_t REG_R17 = 6'd17;
  localparam reg_num_t REG_R18 = 6'd18;
  localparam reg_num_t REG_R19 = 6'd19;

  // Status selects in R15
  localparam status_sel_t STATUS_S0 = 4'd0;
  localparam status_sel_t STATUS_S1 = 4'd1;
  localparam status_sel_t STATUS_S2 = 4'd2;

  localparam logic [4:0] VDP_ID        = 5'd2;
  localparam reg_data_t  STATUS_UNUSED = 8'hFF;

  typedef enum logic [3:0] {
    MODE_GRAPHIC1,
    MODE_GRAPHIC2,
    MODE_GRAPHIC3,
    MODE_GRAPHIC4,
    MODE_GRAPHIC5,
    MODE_GRAPHIC6,
    MODE_GRAPHIC7,
    MODE_TEXT1,
    MODE_TEXT2,
    MODE_MULTI,
    MODE_UNDEF
  } disp_mode_t;

  typedef struct packed {
    logic      hsync_int_en;
    logic      vsync_int_en;
    logic      disp_on;
    logic      sp_size;
    logic      sp_zoom;
    logic      bl_clks;
    logic      pal_mode;
    logic      interlace;
    logic      y_dots;
    reg_data_t frame_col;
    reg_data_t adjust;
    reg_data_t hsync_int_line;
  } ctrl_regs_t;

endpackage

/* vdp_bus_pkg.sv */
// CPU port numbers and the write records passed between the VDP blocks
// Palette channels are 4 bits wide, the low bit is always written as 0

package vdp_bus_pkg;

  typedef logic [1:0] port_t;

  localparam port_t PORT_VRAM     = 2'd0;
  localparam port_t PORT_CTRL     = 2'd1;
  localparam port_t PORT_PAL      = 2'd2;
  localparam port_t PORT_INDIRECT = 2'd3;

  localparam int PAL_COLOR_W = 4;

  typedef logic [PAL_COLOR_W-1:0] pal_color_t;

  typedef struct packed {
    logic                   valid;
    vdp_reg_pkg::reg_num_t  num;
    vdp_reg_pkg::reg_data_t data;
  } reg_wr_t;

  typedef struct packed {
    pal_color_t r;
    pal_color_t g;
    pal_color_t b;
  } pal_entry_t;

  typedef struct packed {
    logic                  valid;
    vdp_reg_pkg::pal_idx_t idx;
    pal_entry_t            entry;
  } pal_wr_t;

endpackage

/* vdp_cpu_port.sv */
// CPU side sequencer for the VDP ports
// Assumes req is a single cycle pulse with at least one idle cycle between
// Port 1 second bytes of the form 0x (VRAM address setup) are ignored
// Port 0 accesses have no effect

`timescale 1ns/1ps

module vdp_cpu_port
  import vdp_reg_pkg::*, vdp_bus_pkg::*;
(
  input  logic      RESET,
  input  logic      CLK21M,
  input  logic      req,
  input  logic      wrt,
  input  port_t     port,
  input  reg_data_t dbo,
  output logic      ack,
  input  pal_idx_t  r16_idx,
  input  logic      r16_load,
  input  reg_num_t  r17_ptr,
  input  logic      r17_inc,
  output reg_wr_t   reg_wr,
  output pal_wr_t   pal_wr
);

  typedef enum logic {P1_FIRST, P1_SECOND} p1_phase_t;
  typedef enum logic {PAL_RB, PAL_G} pal_phase_t;

  p1_phase_t  p1_phase;
  pal_phase_t pal_phase;
  reg_data_t  p1_byte;
  reg_data_t  rb_byte;
  pal_idx_t   pal_idx;
  reg_num_t   ind_ptr;
  logic       ptr_reload;

  logic       wr_req;
  logic       rd_req;
  pal_idx_t   cur_pal_idx;
  pal_phase_t cur_pal_phase;
  reg_num_t   cur_ptr;

  assign wr_req = req & wrt;
  assign rd_req = req & ~wrt;

  // R16/R17 values appear on the bank outputs one cycle after reg_wr
  assign cur_pal_idx   = r16_load ? r16_idx : pal_idx;
  assign cur_pal_phase = r16_load ? PAL_RB : pal_phase;
  assign cur_ptr       = ptr_reload ? r17_ptr : ind_ptr;

  // First byte and red/blue byte buffers
  always_ff @(posedge RESET) begin
    if (wr_req && port == PORT_CTRL && p1_phase == P1_FIRST) begin
      p1_byte <= dbo;
    end
    if (wr_req && port == PORT_PAL && cur_pal_phase == PAL_RB) begin
      rb_byte <= dbo;
    end
  end

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ack        <= 1'b0;
      p1_phase   <= P1_FIRST;
      pal_phase  <= PAL_RB;
      pal_idx    <= '0;
      ind_ptr    <= '0;
      ptr_reload <= 1'b0;
      reg_wr     <= '0;
      pal_wr     <= '0;
    end else begin
      ack          <= req;
      reg_wr.valid <= 1'b0;
      pal_wr.valid <= 1'b0;
      ptr_reload   <= reg_wr.valid && reg_wr.num == REG_R17;
      pal_idx      <= cur_pal_idx;
      pal_phase    <= cur_pal_phase;
      ind_ptr      <= cur_ptr;
      // Status read restarts the two byte sequence
      if (rd_req && port == PORT_CTRL) begin
        p1_phase <= P1_FIRST;
      end
      if (wr_req) begin
        case (port)
          PORT_VRAM: begin
            // VRAM data port lives outside this unit
          end
          PORT_CTRL: begin
            if (p1_phase == P1_FIRST) begin
              p1_phase <= P1_SECOND;
            end else begin
              p1_phase <= P1_FIRST;
              if (dbo[7]) begin
                reg_wr <= '{valid: 1'b1, num: dbo[5:0], data: p1_byte};
              end
            end
          end
          PORT_PAL: begin
            if (cur_pal_phase == PAL_RB) begin
              pal_phase <= PAL_G;
            end else begin
              pal_phase <= PAL_RB;
              pal_idx   <= cur_pal_idx + 4'd1;
              // 3 bit channels padded with a low zero
              pal_wr <= '{valid: 1'b1,
                          idx:   cur_pal_idx,
                          entry: '{r: {rb_byte[6:4], 1'b0},
                                   g: {dbo[2:0], 1'b0},
                                   b: {rb_byte[2:0], 1'b0}}};
            end
          end
          PORT_INDIRECT: begin
            // R17 protects itself, pointer still advances
            if (cur_ptr != REG_R17) begin
              reg_wr <= '{valid: 1'b1, num: cur_ptr, data: dbo};
            end
            ind_ptr <= cur_ptr + reg_num_t'(r17_inc);
          end
        endcase
      end
    end
  end

  a_reg_wr_pulse: assert property (@(posedge RESET) disable iff (CLK21M)
    reg_wr.valid |=> !reg_wr.valid);

endmodule

/* vdp_ctrl_regs.sv */
// Control register bank R0, R1, R7, R9, R15-R19
// Display mode and display enable take effect on the next hsync cycle
// Mode patterns outside the standard table decode to MODE_UNDEF

`timescale 1ns/1ps

module vdp_ctrl_regs
  import vdp_reg_pkg::*, vdp_bus_pkg::*;
(
  input  logic        RESET,
  input  logic        CLK21M,
  input  logic        hsync,
  input  reg_wr_t     reg_wr,
  output ctrl_regs_t  ctrl,
  output disp_mode_t  mode,
  output status_sel_t r15_sel,
  output pal_idx_t    r16_idx,
  output logic        r16_load,
  output reg_num_t    r17_ptr,
  output logic        r17_inc,
  output logic        hclr_by_write
);

  logic [2:0] r0_mode_stg;
  logic [1:0] r1_mode_stg;
  logic       disp_on_stg;
  logic [2:0] r0_mode;
  logic [1:0] r1_mode;
  logic [4:0] mode_key;
  reg_data_t  wd;

  assign wd = reg_wr.data;

  // ------------------------------------------------------------
  // Register writes and hsync latch
  // ------------------------------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ctrl        <= '0;
      r0_mode_stg <= '0;
      r1_mode_stg <= '0;
      disp_on_stg <= 1'b0;
      r0_mode     <= '0;
      r1_mode     <= '0;
      r15_sel     <= '0;
      r16_idx     <= '0;
      r16_load    <= 1'b0;
      r17_ptr     <= '0;
      r17_inc     <= 1'b0;
    end else begin
      r16_load <= 1'b0;
      if (hsync) begin
        ctrl.disp_on <= disp_on_stg;
        r0_mode      <= r0_mode_stg;
        r1_mode      <= r1_mode_stg;
      end
      if (reg_wr.valid) begin
        case (reg_wr.num)
          REG_R0: begin
            ctrl.hsync_int_en <= wd[4];
            r0_mode_stg       <= wd[3:1];
          end
          REG_R1: begin
            ctrl.sp_zoom      <= wd[0];
            ctrl.sp_size      <= wd[1];
            ctrl.bl_clks      <= wd[2];
            r1_mode_stg       <= wd[4:3];
            ctrl.vsync_int_en <= wd[5];
            disp_on_stg       <= wd[6];
          end
          REG_R7:  ctrl.frame_col <= wd;
          REG_R9: begin
            ctrl.pal_mode  <= wd[1];
            ctrl.interlace <= wd[3];
            ctrl.y_dots    <= wd[7];
          end
          REG_R15: r15_sel <= wd[3:0];
          REG_R16: begin
            r16_idx  <= wd[3:0];
            r16_load <= 1'b1;
          end
          REG_R17: begin
            r17_ptr <= wd[5:0];
            // Bit 7 set means no auto increment
            r17_inc <= ~wd[7];
          end
          REG_R18: ctrl.adjust <= wd;
          REG_R19: ctrl.hsync_int_line <= wd;
          default: begin
          end
        endcase
      end
    end
  end

  // Writing R19, or R0 with IE1 set, drops a pending line interrupt
  assign hclr_by_write = reg_wr.valid &&
                         (reg_wr.num == REG_R19 || (reg_wr.num == REG_R0 && wd[4]));

  // Key is M5 M4 M3 M2 M1
  assign mode_key = {r0_mode, r1_mode[0], r1_mode[1]};

  always_comb begin
    case (mode_key)
      5'b00000: mode = MODE_GRAPHIC1;
      5'b00001: mode = MODE_TEXT1;
      5'b00010: mode = MODE_MULTI;
      5'b00100: mode = MODE_GRAPHIC2;
      5'b01000: mode = MODE_GRAPHIC3;
      5'b01001: mode = MODE_TEXT2;
      5'b01100: mode = MODE_GRAPHIC4;
      5'b10000: mode = MODE_GRAPHIC5;
      5'b10100: mode = MODE_GRAPHIC6;
      5'b11100: mode = MODE_GRAPHIC7;
      default:  mode = MODE_UNDEF;
    endcase
  end

  a_mode_defined: assert property (@(posedge RESET) disable iff (CLK21M)
    hsync && disp_on_stg |=> mode != MODE_UNDEF);

endmodule

/* vdp_palette.sv */
// 16 entry palette RAM with 4 bit red, green and blue channels
// Writes wait for an odd dot state (01 or 10) before they commit
// A newer write replaces one that has not committed yet
// pal_data lags pal_addr by one cycle and is stale in commit cycles

`timescale 1ns/1ps

module vdp_palette
  import vdp_reg_pkg::*, vdp_bus_pkg::*;
(
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic [1:0] dotstate,
  input  pal_wr_t    pal_wr,
  input  pal_idx_t   pal_addr,
  output pal_entry_t pal_data
);

  pal_entry_t mem [PAL_DEPTH];

  logic       wr_req;
  logic       wr_ack;
  pal_idx_t   pend_idx;
  pal_entry_t pend_entry;
  logic       odd_dot;
  logic       pal_we;
  pal_idx_t   ram_addr;

  assign odd_dot  = dotstate[1] ^ dotstate[0];
  assign pal_we   = odd_dot && (wr_req != wr_ack);
  assign ram_addr = pal_we ? pend_idx : pal_addr;

  // ------------------------------------------------------------
  // Request toggle pair
  // ------------------------------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      wr_req <= 1'b0;
      wr_ack <= 1'b0;
    end else begin
      if (pal_we) begin
        wr_ack <= ~wr_ack;
      end
      // Keep the new request pending even if the old one commits now
      if (pal_wr.valid) begin
        wr_req <= pal_we ? wr_ack : ~wr_ack;
      end
    end
  end

  always_ff @(posedge RESET) begin
    if (pal_wr.valid) begin
      pend_idx   <= pal_wr.idx;
      pend_entry <= pal_wr.entry;
    end
  end

  // Single port RAM shared by commit and display read
  always_ff @(posedge RESET) begin
    if (pal_we) begin
      mem[ram_addr] <= pend_entry;
    end
    pal_data <= mem[ram_addr];
  end

  // A pending write stays pending through even dot states
  a_hold_even: assert property (@(posedge RESET) disable iff (CLK21M)
    !odd_dot && (wr_req != wr_ack) |=> wr_req != wr_ack);

endmodule

/* vdp_status_read.sv */
// CPU read data for status registers S#0, S#1 and S#2
// Other status selects and the other ports read as 0xFF
// status_in bit 0 is reserved

`timescale 1ns/1ps

module vdp_status_read
  import vdp_reg_pkg::*, vdp_bus_pkg::*;
(
  input  logic        RESET,
  input  logic        CLK21M,
  input  logic        req,
  input  logic        wrt,
  input  port_t       port,
  input  status_sel_t r15_sel,
  input  logic        hclr_by_write,
  input  logic [15:0] status_in,
  output reg_data_t   dbi,
  output logic        clr_vsync_int,
  output logic        clr_hsync_int
);

  typedef struct packed {
    logic       vsync_int_n;
    logic       hsync_int_n;
    logic       overmapped;
    logic       collision;
    logic [4:0] spnum;
    logic       tr;
    logic       vd;
    logic       hd;
    logic       bd;
    logic       field;
    logic       ce;
    logic       rsvd;
  } status_flags_t;

  status_flags_t flags;
  logic          rd_req;
  logic          s_rd;
  reg_data_t     s0;
  reg_data_t     s1;
  reg_data_t     s2;

  assign flags  = status_in;
  assign rd_req = req & ~wrt;
  assign s_rd   = rd_req && port == PORT_CTRL;

  assign s0 = {~flags.vsync_int_n, flags.overmapped, flags.collision, flags.spnum};
  assign s1 = {2'b00, VDP_ID, ~flags.hsync_int_n};
  assign s2 = {flags.tr, flags.vd, flags.hd, flags.bd, 2'b11, flags.field, flags.ce};

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      dbi           <= '0;
      clr_vsync_int <= 1'b0;
      clr_hsync_int <= 1'b0;
    end else begin
      clr_vsync_int <= s_rd && r15_sel == STATUS_S0;
      clr_hsync_int <= (s_rd && r15_sel == STATUS_S1) || hclr_by_write;
      // dbi holds its value between reads
      if (rd_req) begin
        if (port != PORT_CTRL) begin
          dbi <= STATUS_UNUSED;
        end else begin
          case (r15_sel)
            STATUS_S0: dbi <= s0;
            STATUS_S1: dbi <= s1;
            STATUS_S2: dbi <= s2;
            default:   dbi <= STATUS_UNUSED;
          endcase
        end
      end
    end
  end

endmodule

/* vdp_register_top.sv */
// CPU register unit of an MSX2 style VDP
// RESET is the clock, CLK21M the asynchronous active high reset
// ack follows req by one cycle, there is no back pressure

`timescale 1ns/1ps

module vdp_register_top
  import vdp_reg_pkg::*, vdp_bus_pkg::*;
(
  input  logic        RESET,
  input  logic        CLK21M,
  input  logic        req,
  input  logic        wrt,
  input  port_t       port,
  input  reg_data_t   dbo,
  output logic        ack,
  output reg_data_t   dbi,
  input  logic        hsync,
  input  logic [1:0]  dotstate,
  input  logic [15:0] status_in,
  input  pal_idx_t    pal_addr,
  output pal_entry_t  pal_data,
  output ctrl_regs_t  ctrl,
  output disp_mode_t  mode,
  output logic        clr_vsync_int,
  output logic        clr_hsync_int
);

  reg_wr_t     reg_wr;
  pal_wr_t     pal_wr;
  status_sel_t r15_sel;
  pal_idx_t    r16_idx;
  logic        r16_load;
  reg_num_t    r17_ptr;
  logic        r17_inc;
  logic        hclr_by_write;

  vdp_cpu_port u_cpu_port (
    .RESET    (RESET),
    .CLK21M   (CLK21M),
    .req      (req),
    .wrt      (wrt),
    .port     (port),
    .dbo      (dbo),
    .ack      (ack),
    .r16_idx  (r16_idx),
    .r16_load (r16_load),
    .r17_ptr  (r17_ptr),
    .r17_inc  (r17_inc),
    .reg_wr   (reg_wr),
    .pal_wr   (pal_wr)
  );

  vdp_ctrl_regs u_ctrl_regs (
    .RESET         (RESET),
    .CLK21M        (CLK21M),
    .hsync         (hsync),
    .reg_wr        (reg_wr),
    .ctrl          (ctrl),
    .mode          (mode),
    .r15_sel       (r15_sel),
    .r16_idx       (r16_idx),
    .r16_load      (r16_load),
    .r17_ptr       (r17_ptr),
    .r17_inc       (r17_inc),
    .hclr_by_write (hclr_by_write)
  );

  vdp_palette u_palette (
    .RESET    (RESET),
    .CLK21M   (CLK21M),
    .dotstate (dotstate),
    .pal_wr   (pal_wr),
    .pal_addr (pal_addr),
    .pal_data (pal_data)
  );

  vdp_status_read u_status_read (
    .RESET         (RESET),
    .CLK21M        (CLK21M),
    .req           (req),
    .wrt           (wrt),
    .port          (port),
    .r15_sel       (r15_sel),
    .hclr_by_write (hclr_by_write),
    .status_in     (status_in),
    .dbi           (dbi),
    .clr_vsync_int (clr_vsync_int),
    .clr_hsync_int (clr_hsync_int)
  );

endmodule

/* tb_vdp_tests.svh */
// Directed tests for the VDP register unit, included inside tb_vdp_register
// Expected values follow the MSX2 register and status bit layouts
// exp_ctrl models the control bank as the CPU has written it

`ifndef TB_VDP_TESTS_SVH
`define TB_VDP_TESTS_SVH

ctrl_regs_t exp_ctrl;
disp_mode_t exp_mode;

// Standard MSX2 mode table, bits ordered M5 M4 M3 M2 M1
function automatic disp_mode_t mode_from_bits(input reg_data_t r0, input reg_data_t r1);
  logic [4:0] m;
  m = {r0[3], r0[2], r0[1], r1[3], r1[4]};
  case (m)
    5'b00000: return MODE_GRAPHIC1;
    5'b00001: return MODE_TEXT1;
    5'b00010: return MODE_MULTI;
    5'b00100: return MODE_GRAPHIC2;
    5'b01000: return MODE_GRAPHIC3;
    5'b01001: return MODE_TEXT2;
    5'b01100: return MODE_GRAPHIC4;
    5'b10000: return MODE_GRAPHIC5;
    5'b10100: return MODE_GRAPHIC6;
    5'b11100: return MODE_GRAPHIC7;
    default:  return MODE_UNDEF;
  endcase
endfunction

// 3 bit channels padded with a low zero
function automatic pal_entry_t expand_entry(input reg_data_t rb, input reg_data_t g);
  pal_entry_t e;
  e.r = {rb[6:4], 1'b0};
  e.g = {g[2:0], 1'b0};
  e.b = {rb[2:0], 1'b0};
  return e;
endfunction

task automatic pulse_hsync();
  @(posedge RESET);
  hsync <= 1'b1;
  @(posedge RESET);
  hsync <= 1'b0;
  @(negedge RESET);
endtask

task automatic hold_dotstate(input logic [1:0] value, input int cycles);
  @(posedge RESET);
  dotstate <= value;
  repeat (cycles) @(posedge RESET);
endtask

task automatic read_palette(input pal_idx_t idx, output pal_entry_t got);
  @(posedge RESET);
  pal_addr <= idx;
  @(posedge RESET);
  @(negedge RESET);
  got = pal_data;
endtask

// ------------------------------------------------------------
// Tests
// ------------------------------------------------------------
task automatic reset_values();
  @(negedge RESET);
  exp_ctrl = '0;
  exp_mode = mode_from_bits(8'h00, 8'h00);
  bit_check("ack", ack, 1'b0);
  byte_check("dbi", dbi, 8'h00);
  bit_check("clr_vsync_int", clr_vsync_int, 1'b0);
  bit_check("clr_hsync_int", clr_hsync_int, 1'b0);
  ctrl_check("ctrl", ctrl, exp_ctrl);
  mode_check("mode", mode, exp_mode);
  report_test("reset_values");
endtask

task automatic direct_writes();
  reg_data_t d7;
  reg_data_t d19;
  logic      h;
  d7  = rand_byte();
  d19 = rand_byte();
  write_reg(REG_R7, d7, h);
  exp_ctrl.frame_col = d7;
  ctrl_check("ctrl", ctrl, exp_ctrl);
  bit_check("clr_hsync_int", h, 1'b0);
  write_reg(REG_R19, d19, h);
  exp_ctrl.hsync_int_line = d19;
  ctrl_check("ctrl", ctrl, exp_ctrl);
  bit_check("clr_hsync_int", h, 1'b1);
  // Second byte 0x is a VRAM address setup and leaves the bank alone
  write_port(PORT_CTRL, rand_byte());
  write_port(PORT_CTRL, 8'h07);
  @(negedge RESET);
  ctrl_check("ctrl", ctrl, exp_ctrl);
  report_test("direct_writes");
endtask

task automatic indirect_writes();
  reg_data_t d7;
  reg_data_t d9;
  reg_data_t d18;
  logic      h;
  d7  = rand_byte();
  d9  = rand_byte();
  d18 = rand_byte();
  write_reg(REG_R17, 8'h07, h);
  write_port(PORT_INDIRECT, d7);
  write_port(PORT_INDIRECT, rand_byte());
  write_port(PORT_INDIRECT, d9);
  @(negedge RESET);
  exp_ctrl.frame_col = d7;
  exp_ctrl.pal_mode  = d9[1];
  exp_ctrl.interlace = d9[3];
  exp_ctrl.y_dots    = d9[7];
  ctrl_check("ctrl", ctrl, exp_ctrl);
  // Byte aimed at R17 is dropped, the next one still reaches R18
  write_reg(REG_R17, 8'h11, h);
  write_port(PORT_INDIRECT, 8'h07);
  write_port(PORT_INDIRECT, d18);
  @(negedge RESET);
  exp_ctrl.adjust = d18;
  ctrl_check("ctrl", ctrl, exp_ctrl);
  report_test("indirect_writes");
endtask

task automatic mode_step(input reg_data_t r0, input reg_data_t r1_mode, input logic on);
  reg_data_t r1;
  logic      h;
  r1 = (rand_byte() & 8'h27) | r1_mode | {1'b0, on, 6'b000000};
  write_reg(REG_R0, r0, h);
  write_reg(REG_R1, r1, h);
  exp_ctrl.hsync_int_en = r0[4];
  exp_ctrl.sp_zoom      = r1[0];
  exp_ctrl.sp_size      = r1[1];
  exp_ctrl.bl_clks      = r1[2];
  exp_ctrl.vsync_int_en = r1[5];
  @(negedge RESET);
  mode_check("mode before hsync", mode, exp_mode);
  ctrl_check("ctrl before hsync", ctrl, exp_ctrl);
  pulse_hsync();
  exp_ctrl.disp_on = on;
  exp_mode = mode_from_bits(r0, r1);
  mode_check("mode", mode, exp_mode);
  ctrl_check("ctrl", ctrl, exp_ctrl);
endtask

task automatic mode_latch();
  // Graphic4, then text2 with the display off, then graphic7
  mode_step(8'h06, 8'h00, 1'b1);
  mode_step(8'h04, 8'h10, 1'b0);
  mode_step(8'h0E, 8'h00, 1'b1);
  report_test("mode_latch");
endtask

task automatic status_reads();
  logic [15:0] s;
  reg_data_t   rd;
  logic        v;
  logic        h;
  s = rand_bits(16);
  @(posedge RESET);
  status_in <= s;
  write_reg(REG_R15, 8'h00, h);
  read_port(PORT_CTRL, rd, v, h);
  byte_check("dbi S#0", rd, {~s[15], s[13], s[12], s[11:7]});
  bit_check("clr_vsync_int", v, 1'b1);
  bit_check("clr_hsync_int", h, 1'b0);
  write_reg(REG_R15, 8'h01, h);
  read_port(PORT_CTRL, rd, v, h);
  byte_check("dbi S#1", rd, {2'b00, 5'd2, ~s[14]});
  bit_check("clr_vsync_int", v, 1'b0);
  bit_check("clr_hsync_int", h, 1'b1);
  write_reg(REG_R15, 8'h02, h);
  read_port(PORT_CTRL, rd, v, h);
  byte_check("dbi S#2", rd, {s[6], s[5], s[4], s[3], 2'b11, s[2], s[1]});
  write_reg(REG_R15, 8'h05, h);
  read_port(PORT_CTRL, rd, v, h);
  byte_check("dbi S#5", rd, 8'hFF);
  read_port(PORT_VRAM, rd, v, h);
  byte_check("dbi port 0", rd, 8'hFF);
  report_test("status_reads");
endtask

task automatic palette_writes();
  reg_data_t  rb3;
  reg_data_t  g3;
  reg_data_t  rb4;
  reg_data_t  g4;
  pal_entry_t got;
  logic       h;
  rb3 = rand_byte();
  g3  = rand_byte();
  rb4 = rand_byte();
  g4  = rand_byte();
  hold_dotstate(2'b00, 1);
  // Entries 3 and 4 start out with the inverted bytes
  write_reg(REG_R16, 8'h03, h);
  write_port(PORT_PAL, ~rb3);
  write_port(PORT_PAL, ~g3);
  hold_dotstate(2'b01, 2);
  hold_dotstate(2'b00, 1);
  write_port(PORT_PAL, ~rb4);
  write_port(PORT_PAL, ~g4);
  hold_dotstate(2'b10, 2);
  hold_dotstate(2'b00, 1);
  read_palette(4'd3, got);
  entry_check("pal_data[3] first fill", got, expand_entry(~rb3, ~g3));
  read_palette(4'd4, got);
  entry_check("pal_data[4] first fill", got, expand_entry(~rb4, ~g4));
  write_reg(REG_R16, 8'h03, h);
  write_port(PORT_PAL, rb3);
  write_port(PORT_PAL, g3);
  hold_dotstate(2'b00, 4);
  read_palette(4'd3, got);
  entry_check("pal_data[3] in even dot", got, expand_entry(~rb3, ~g3));
  hold_dotstate(2'b01, 2);
  hold_dotstate(2'b00, 1);
  write_port(PORT_PAL, rb4);
  write_port(PORT_PAL, g4);
  hold_dotstate(2'b00, 4);
  read_palette(4'd4, got);
  entry_check("pal_data[4] in even dot", got, expand_entry(~rb4, ~g4));
  hold_dotstate(2'b10, 2);
  hold_dotstate(2'b00, 1);
  read_palette(4'd3, got);
  entry_check("pal_data[3]", got, expand_entry(rb3, g3));
  read_palette(4'd4, got);
  entry_check("pal_data[4]", got, expand_entry(rb4, g4));
  report_test("palette_writes");
endtask

`endif

/* tb_vdp_register.sv */
// Testbench for the VDP CPU register unit
// Directed tests come from tb_vdp_tests.svh, data bytes from a 16 bit Galois LFSR
// Inputs change on the rising clock edge, outputs are sampled on the falling edge
// A watchdog ends the run if the tests take far longer than planned

`timescale 1ns/1ps

module tb_vdp_register
  import vdp_reg_pkg::*, vdp_bus_pkg::*;
;

  localparam int          CLK_PERIOD_NS = 4;
  localparam int          RESET_CYCLES  = 16;
  localparam int          ACK_LIMIT     = 8;
  localparam logic [15:0] LFSR_SEED     = 16'd86;
  localparam logic [15:0] LFSR_TAPS     = 16'hB400;

  // Upper bound of bus accesses in all tests, each about 4 cycles,
  // plus the hsync pulses, dot state holds and palette reads
  localparam int ACCESS_COUNT    = 64;
  localparam int ACCESS_CYCLES   = 4;
  localparam int EXTRA_CYCLES    = 150;
  localparam int WATCHDOG_CYCLES =
    2 * (RESET_CYCLES + ACCESS_COUNT * ACCESS_CYCLES + EXTRA_CYCLES);

  logic        RESET;
  logic        CLK21M;
  logic        req;
  logic        wrt;
  port_t       port;
  reg_data_t   dbo;
  logic        ack;
  reg_data_t   dbi;
  logic        hsync;
  logic [1:0]  dotstate;
  logic [15:0] status_in;
  pal_idx_t    pal_addr;
  pal_entry_t  pal_data;
  ctrl_regs_t  ctrl;
  disp_mode_t  mode;
  logic        clr_vsync_int;
  logic        clr_hsync_int;

  int          check_count   = 0;
  int          error_count   = 0;
  int          test_err_base = 0;
  logic [15:0] lfsr_state    = LFSR_SEED;

  vdp_register_top u_vdp_register_top (
    .RESET         (RESET),
    .CLK21M        (CLK21M),
    .req           (req),
    .wrt           (wrt),
    .port          (port),
    .dbo           (dbo),
    .ack           (ack),
    .dbi           (dbi),
    .hsync         (hsync),
    .dotstate      (dotstate),
    .status_in     (status_in),
    .pal_addr      (pal_addr),
    .pal_data      (pal_data),
    .ctrl          (ctrl),
    .mode          (mode),
    .clr_vsync_int (clr_vsync_int),
    .clr_hsync_int (clr_hsync_int)
  );

  initial begin
    RESET = 1'b0;
    forever #(CLK_PERIOD_NS / 2) RESET = ~RESET;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // Random data
  // ------------------------------------------------------------
  function automatic logic [15:0] rand_bits(input int count);
    logic [15:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      bits = {bits[14:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return bits;
  endfunction

  function automatic reg_data_t rand_byte();
    logic [15:0] bits;
    bits = rand_bits(8);
    return bits[7:0];
  endfunction

  // ------------------------------------------------------------
  // Compare tasks and reporting
  // ------------------------------------------------------------
  task automatic note_failure(input string what);
    error_count++;
    $display("error: %s", what);
  endtask

  task automatic byte_check(input string name, input reg_data_t got, input reg_data_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic bit_check(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic ctrl_check(input string name, input ctrl_regs_t got, input ctrl_regs_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic mode_check(input string name, input disp_mode_t got, input disp_mode_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic entry_check(input string name, input pal_entry_t got, input pal_entry_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = error_count - test_err_base;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errs);
    end
    test_err_base = error_count;
  endtask

  // ------------------------------------------------------------
  // CPU bus access
  // ------------------------------------------------------------
  // One req pulse, then wait for ack and sample the read side outputs
  task automatic cpu_access(input logic is_write, input port_t p, input reg_data_t d,
                            output reg_data_t rd, output logic clr_v, output logic clr_h);
    int waited;
    waited = 0;
    @(posedge RESET);
    req  <= 1'b1;
    wrt  <= is_write;
    port <= p;
    dbo  <= d;
    @(posedge RESET);
    req <= 1'b0;
    @(negedge RESET);
    while (!ack && waited < ACK_LIMIT) begin
      waited++;
      @(negedge RESET);
    end
    rd    = dbi;
    clr_v = clr_vsync_int;
    clr_h = clr_hsync_int;
    check_count++;
    if (!ack) begin
      note_failure($sformatf("no ack within %0d cycles of a request on port %0d",
                             ACK_LIMIT, p));
    end else if (waited != 0) begin
      note_failure($sformatf("ack came %0d cycles late on port %0d", waited, p));
    end
  endtask

  task automatic write_port(input port_t p, input reg_data_t d);
    reg_data_t rd;
    logic      clr_v;
    logic      clr_h;
    cpu_access(1'b1, p, d, rd, clr_v, clr_h);
  endtask

  task automatic read_port(input port_t p, output reg_data_t rd,
                           output logic clr_v, output logic clr_h);
    cpu_access(1'b0, p, 8'h00, rd, clr_v, clr_h);
  endtask

  // Two byte write on port 1, returns at the cycle where ctrl shows the value
  task automatic write_reg(input reg_num_t num, input reg_data_t d, output logic clr_h);
    write_port(PORT_CTRL, d);
    write_port(PORT_CTRL, {2'b10, num});
    @(negedge RESET);
    clr_h = clr_hsync_int;
  endtask

  `include "tb_vdp_tests.svh"

  initial begin
    CLK21M    = 1'b1;
    req       = 1'b0;
    wrt       = 1'b0;
    port      = PORT_VRAM;
    dbo       = '0;
    hsync     = 1'b0;
    dotstate  = 2'b00;
    status_in = '0;
    pal_addr  = '0;
    repeat (RESET_CYCLES) @(posedge RESET);
    CLK21M <= 1'b0;
    reset_values();
    direct_writes();
    indirect_writes();
    mode_latch();
    status_reads();
    palette_writes();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+.
vdp_reg_pkg.sv
vdp_bus_pkg.sv
vdp_cpu_port.sv
vdp_ctrl_regs.sv
vdp_palette.sv
vdp_status_read.sv
vdp_register_top.sv
tb_vdp_register.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_vdp_register -f src.f \
  && ./obj_dir/Vtb_vdp_register > sim.log \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "Simulation finished: PASS" sim.log \
  && { echo "result: pass"; exit 0; } \
  || { echo "result: fail"; exit 1; }
